/* filelist.f */
design/hdc_pkg.sv
design/bundle_ctrl_pkg.sv
design/vote_counter.sv
design/batch_counter.sv
design/bundle_fsm.sv
design/bundle_buffer.sv
design/bundle_top.sv
testbench/tb_bundle.sv

/* Makefile */
# Verilator build for the bundling unit testbench
VERILATOR ?= verilator
TOP       ?= tb_bundle
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# a failing check ends in $fatal, which gives a nonzero exit status
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* testbench/tb_bundle.sv */
module tb_bundle
    import hdc_pkg::*;
    import bundle_ctrl_pkg::*;
();

    // one bundle per row; batches is the ceiling of count over four
    typedef struct packed {
        logic [COUNT_W-1:0] count;
        logic [7:0]         batches;
        logic [1:0]         gap;
        logic               rand_gap;
        logic               stray;
    } bundle_case_t;

    localparam int NUM_CASES = 10;

    logic        clk;
    logic        rst_n;
    logic        start;
    logic [COUNT_W-1:0] sample_count;
    hv_t         tie_hv;
    logic        batch_v;
    core_batch_t batch;
    logic        busy;
    logic        hv_v;
    hv_t         hv;

    bundle_case_t cases [NUM_CASES];
    int          votes [DIM];
    logic [31:0] seed = 32'hbb11_5a1b;
    int          cycles = 0;
    int          cycle_limit = 100000;

    bundle_top uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .sample_count (sample_count),
        .tie_hv       (tie_hv),
        .batch_v      (batch_v),
        .batch        (batch),
        .busy         (busy),
        .hv_v         (hv_v),
        .hv           (hv)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("SIMULATION FAILED");
        $fatal(1, "run aborted");
    endtask

    // guard against a DUT that never answers
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            abort_run($sformatf("run timed out after %0d cycles", cycles));
        end
    end

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_hv(input string name, input hv_t got, input hv_t exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
        end
    endtask

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic draw_hv(output hv_t v);
        logic [31:0] hi;
        seed = lcg_step(seed);
        hi = seed;
        seed = lcg_step(seed);
        v = {hi, seed};
    endtask

    task automatic draw_batch(output core_batch_t bt);
        draw_hv(bt.core0);
        draw_hv(bt.core1);
        draw_hv(bt.core2);
        draw_hv(bt.core3);
    endtask

    // reference vote model, one signed total per dimension
    task automatic model_clear(input hv_t tie_vec, input logic even);
        for (int i = 0; i < DIM; i++) begin
            votes[i] = even ? (tie_vec[i] ? 1 : -1) : 0;
        end
    endtask

    task automatic model_add(input core_batch_t bt, input int valid);
        hv_t cores [NUM_CORES];
        cores[0] = bt.core0;
        cores[1] = bt.core1;
        cores[2] = bt.core2;
        cores[3] = bt.core3;
        for (int i = 0; i < DIM; i++) begin
            for (int k = 0; k < valid; k++) begin
                votes[i] += cores[k][i] ? 1 : -1;
            end
        end
    endtask

    function automatic hv_t model_result();
        hv_t r;
        for (int i = 0; i < DIM; i++) begin
            r[i] = (votes[i] > 0);
        end
        return r;
    endfunction

    initial begin
        bundle_case_t tc;
        hv_t          tie;
        hv_t          exp_hv;
        hv_t          prev_hv;
        core_batch_t  bt;
        int           nb;
        int           g;
        int           rem;
        int           valid;
        int           waited;

        // count, batches, gap, random gap, stray strobes
        cases = '{
            '{8'd1,   8'd1,  2'd0, 1'b0, 1'b0},
            '{8'd4,   8'd1,  2'd0, 1'b0, 1'b0},
            '{8'd8,   8'd2,  2'd1, 1'b0, 1'b0},
            '{8'd7,   8'd2,  2'd0, 1'b1, 1'b0},
            '{8'd10,  8'd3,  2'd0, 1'b1, 1'b0},
            '{8'd5,   8'd2,  2'd1, 1'b0, 1'b1},
            '{8'd2,   8'd1,  2'd0, 1'b0, 1'b0},
            '{8'd3,   8'd1,  2'd0, 1'b1, 1'b1},
            '{8'd255, 8'd64, 2'd0, 1'b0, 1'b0},
            '{8'd12,  8'd3,  2'd2, 1'b0, 1'b1}
        };
        // random gaps are at most 2, budget 3
        cycle_limit = 5 + 50;
        for (int c = 0; c < NUM_CASES; c++) begin
            g = cases[c].rand_gap ? 3 : int'(cases[c].gap);
            cycle_limit += int'(cases[c].batches) * (g + 1) + 4 + (cases[c].stray ? 2 : 0);
        end

        rst_n = 1'b0;
        start = 1'b0;
        sample_count = '0;
        tie_hv = '0;
        batch_v = 1'b0;
        batch = '0;
        prev_hv = '0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        check_bit("busy", busy, 1'b0);
        check_bit("hv_v", hv_v, 1'b0);
        check_hv("hv", hv, '0);

        for (int c = 0; c < NUM_CASES; c++) begin
            tc = cases[c];
            nb = int'(tc.batches);
            rem = int'(tc.count) % NUM_CORES;
            if (tc.stray) begin
                // batch strobe while idle must not touch the result
                draw_batch(bt);
                batch = bt;
                batch_v = 1'b1;
                @(negedge clk);
                batch_v = 1'b0;
                check_bit("busy", busy, 1'b0);
                check_hv("hv", hv, prev_hv);
            end
            draw_hv(tie);
            tie_hv = tie;
            sample_count = tc.count;
            start = 1'b1;
            model_clear(tie, ~tc.count[0]);
            @(negedge clk);
            start = 1'b0;
            check_bit("busy", busy, 1'b1);
            for (int b = 0; b < nb; b++) begin
                if (tc.rand_gap) begin
                    seed = lcg_step(seed);
                    g = int'(seed[23:16]) % 3;
                end else begin
                    g = int'(tc.gap);
                end
                repeat (g) begin
                    @(negedge clk);
                    check_bit("busy", busy, 1'b1);
                    check_bit("hv_v", hv_v, 1'b0);
                end
                draw_batch(bt);
                batch = bt;
                batch_v = 1'b1;
                // start while busy, with the other parity
                if (tc.stray) begin
                    start = 1'b1;
                    sample_count = tc.count ^ COUNT_W'(1);
                end
                // upper cores drop out of a partial last batch
                valid = (b == nb - 1 && rem != 0) ? rem : NUM_CORES;
                model_add(bt, valid);
                @(negedge clk);
                batch_v = 1'b0;
                start = 1'b0;
                sample_count = tc.count;
                check_bit("busy", busy, 1'b1);
                check_bit("hv_v", hv_v, 1'b0);
                // previous result holds until the next capture
                check_hv("hv", hv, prev_hv);
            end
            exp_hv = model_result();
            // batch strobe during capture is ignored too
            if (tc.stray) begin
                draw_batch(bt);
                batch = bt;
                batch_v = 1'b1;
            end
            waited = 0;
            do begin
                @(negedge clk);
                batch_v = 1'b0;
                waited++;
                if (!hv_v && waited > 4) begin
                    abort_run("no result pulse within 4 cycles of the last batch");
                end
            end while (!hv_v);
            if (waited != 1) begin
                abort_run($sformatf("result came %0d cycles after the last batch, not 1",
                                    waited));
            end
            check_bit("busy", busy, 1'b0);
            check_hv("hv", hv, exp_hv);
            prev_hv = exp_hv;
            // pulse lasts one cycle, result holds
            @(negedge clk);
            check_bit("hv_v", hv_v, 1'b0);
            check_hv("hv", hv, prev_hv);
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* design/bundle_top.sv */
module bundle_top
    import hdc_pkg::*;
    import bundle_ctrl_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  logic [COUNT_W-1:0] sample_count,
    input  hv_t                tie_hv,
    input  logic               batch_v,
    input  core_batch_t        batch,
    output logic               busy,
    output logic               hv_v,
    output hv_t                hv
);

    bundle_ctrl_t     ctrl;
    logic             last;
    logic [REM_W-1:0] remainder;

    // sequencing and strobe gating
    bundle_fsm u_fsm (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .sample_count (sample_count),
        .batch_v      (batch_v),
        .last         (last),
        .remainder    (remainder),
        .ctrl         (ctrl),
        .busy         (busy),
        .hv_v         (hv_v)
    );

    // loads with the counters, steps with each accepted batch
    batch_counter u_batch_cnt (
        .clk          (clk),
        .rst_n        (rst_n),
        .load         (ctrl.clear),
        .sample_count (sample_count),
        .step         (ctrl.update),
        .last         (last),
        .remainder    (remainder)
    );

    // vote counters and result register
    bundle_buffer u_buffer (
        .clk    (clk),
        .rst_n  (rst_n),
        .ctrl   (ctrl),
        .tie_hv (tie_hv),
        .batch  (batch),
        .hv     (hv)
    );

endmodule

/* design/bundle_buffer.sv */
module bundle_buffer
    import hdc_pkg::*;
    import bundle_ctrl_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  bundle_ctrl_t ctrl,
    input  hv_t          tie_hv,
    input  core_batch_t  batch,
    output hv_t          hv
);

    // live sign of every dimension
    hv_t        sign_vec;
    core_mask_t ignore;

    // on a partial last batch, cores at or above the remainder drop out
    always_comb begin
        for (int k = 0; k < NUM_CORES; k++) begin
            ignore[k] = ctrl.last && (ctrl.remainder != '0)
                        && (int'(ctrl.remainder) <= k);
        end
    end

    // one counter per dimension
    for (genvar i = 0; i < DIM; i++) begin : g_dim
        logic [NUM_CORES-1:0] votes;

        // bit i of each core, core0 lowest
        assign votes = {batch.core3[i], batch.core2[i], batch.core1[i], batch.core0[i]};

        vote_counter u_vote (
            .clk       (clk),
            .rst_n     (rst_n),
            .clear     (ctrl.clear),
            .init_vote (tie_hv[i]),
            .tie_en    (ctrl.even),
            .update    (ctrl.update),
            .votes     (votes),
            .ignore    (ignore),
            .sign_bit  (sign_vec[i])
        );
    end

    // result held until the next capture
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hv <= '0;
        end else if (ctrl.capture) begin
            hv <= sign_vec;
        end
    end

    // counters are idle while the signs are taken
    a_stable_on_capture: assert property (
        @(posedge clk) disable iff (!rst_n)
        ctrl.capture |-> !ctrl.update && !ctrl.clear
    ) else $error("counters moving during capture");

endmodule

/* design/bundle_fsm.sv */
module bundle_fsm
    import bundle_ctrl_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  logic [COUNT_W-1:0] sample_count,
    input  logic               batch_v,
    input  logic               last,
    input  logic [REM_W-1:0]   remainder,
    output bundle_ctrl_t       ctrl,
    output logic               busy,
    output logic               hv_v
);

    bundle_state_t state;
    bundle_state_t state_nxt;

    // strobes only count in their own state
    logic start_ok;
    logic batch_ok;

    assign start_ok = start && (state == IDLE);
    assign batch_ok = batch_v && (state == ACCUM);

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (start_ok) begin
                    state_nxt = ACCUM;
                end
            end
            ACCUM: begin
                // final batch goes straight to capture
                if (batch_ok && last) begin
                    state_nxt = FINISH;
                end
            end
            FINISH: begin
                state_nxt = IDLE;
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // control word towards the buffer
    always_comb begin
        ctrl.clear     = start_ok;
        // odd count never ties, so no extra vote
        ctrl.even      = ~sample_count[0];
        ctrl.update    = batch_ok;
        ctrl.last      = last;
        ctrl.remainder = remainder;
        ctrl.capture   = (state == FINISH);
    end

    assign busy = (state != IDLE);

    // result pulse lines up with the hv register update
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hv_v <= 1'b0;
        end else begin
            hv_v <= ctrl.capture;
        end
    end

    // batch counter is drained once the result is taken
    a_drained_on_capture: assert property (
        @(posedge clk) disable iff (!rst_n)
        ctrl.capture |-> !last
    ) else $error("batches still left at capture");

endmodule

/* design/batch_counter.sv */
module batch_counter
    import hdc_pkg::*;
    import bundle_ctrl_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               load,
    input  logic [COUNT_W-1:0] sample_count,
    input  logic               step,
    output logic               last,
    output logic [REM_W-1:0]   remainder
);

    // batches still expected in this bundle
    logic [COUNT_W-1:0] batches_left;

    // ceiling of sample_count over core count
    logic [COUNT_W-1:0] batch_total;
    logic [REM_W-1:0]   rem_in;

    always_comb begin
        rem_in      = REM_W'(sample_count % NUM_CORES);
        batch_total = COUNT_W'(sample_count / NUM_CORES);
        // partial batch counts as one more
        if (rem_in != '0) begin
            batch_total = batch_total + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            batches_left <= '0;
            remainder    <= '0;
        end else if (load) begin
            batches_left <= batch_total;
            remainder    <= rem_in;
        end else if (step) begin
            batches_left <= batches_left - 1'b1;
        end
    end

    // one batch to go means the next one is final
    assign last = (batches_left == COUNT_W'(1));

    // controller must stop stepping once the count runs out
    a_no_underflow: assert property (
        @(posedge clk) disable iff (!rst_n)
        step && !load |-> batches_left != '0
    ) else $error("batch step with no batches left");

endmodule

/* design/vote_counter.sv */
module vote_counter
    import hdc_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 clear,
    input  logic                 init_vote,
    input  logic                 tie_en,
    input  logic                 update,
    input  logic [NUM_CORES-1:0] votes,
    input  core_mask_t           ignore,
    output logic                 sign_bit
);

    logic signed [CNT_W-1:0] cnt;
    logic signed [CNT_W-1:0] delta;
    // one extra bit to see a wrap
    logic signed [CNT_W:0]   sum_wide;

    // net vote of this batch, +1 per one bit and -1 per zero bit
    always_comb begin
        int net;
        net = 0;
        for (int k = 0; k < NUM_CORES; k++) begin
            if (!ignore[k]) begin
                net = votes[k] ? net + 1 : net - 1;
            end
        end
        delta = CNT_W'(net);
    end

    assign sum_wide = {cnt[CNT_W-1], cnt} + {delta[CNT_W-1], delta};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (clear) begin
            // tie vote only when the count is even
            if (tie_en) begin
                cnt <= init_vote ? CNT_W'(1) : CNT_W'(-1);
            end else begin
                cnt <= '0;
            end
        end else if (update) begin
            cnt <= sum_wide[CNT_W-1:0];
        end
    end

    // strictly positive votes give a one
    assign sign_bit = (cnt > 0);

    // sample count limit keeps the sum in range
    a_no_overflow: assert property (
        @(posedge clk) disable iff (!rst_n)
        update && !clear |-> sum_wide[CNT_W] == sum_wide[CNT_W-1]
    ) else $error("vote counter overflow");

endmodule

/* design/bundle_ctrl_pkg.sv */
package bundle_ctrl_pkg;

    // sample count width, 1 to 255 samples per bundle
    localparam int COUNT_W = 8;

    // sample count mod core count
    localparam int REM_W = 2;

    // bundling sequence
    typedef enum logic [1:0] {
        IDLE,
        ACCUM,
        FINISH
    } bundle_state_t;

    // controller to buffer strobes and qualifiers
    typedef struct packed {
        // load counters with tie vote or zero
        logic             clear;
        // tie vote applies on clear
        logic             even;
        // add one batch of votes
        logic             update;
        // current batch is the final one
        logic             last;
        // cores below this count are valid on the last batch
        logic [REM_W-1:0] remainder;
        // register the sign vector
        logic             capture;
    } bundle_ctrl_t;

endpackage

/* design/hdc_pkg.sv */
package hdc_pkg;

    // hypervector width in bits
    localparam int DIM = 64;

    // encoding cores delivering one vector each per batch
    localparam int NUM_CORES = 4;

    // signed vote counter width
    // 255 samples plus the tie vote still fit
    localparam int CNT_W = 10;

    // one binary hypervector
    typedef logic [DIM-1:0] hv_t;

    // one batch from all cores, core0 in the low bits
    typedef struct packed {
        hv_t core3;
        hv_t core2;
        hv_t core1;
        hv_t core0;
    } core_batch_t;

    // bit k set means core k is left out of the vote
    typedef logic [NUM_CORES-1:0] core_mask_t;

endpackage
